//--- uart_mmio.f
source/uart_mmio_pkg.sv
source/byte_fifo.sv
source/uart_send.sv
source/uart_recv.sv
source/uart_tx_sequencer.sv
source/mmio_uart.sv
verif/tb_mmio_uart.sv

//--- Makefile
# Verilator build and run for the MMIO UART testbench

VERILATOR ?= verilator
TOP       ?= tb_mmio_uart
FILELIST  ?= uart_mmio.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_mmio_uart.sv
module tb_mmio_uart;

    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 4;
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    // 24 frames of serial traffic, then bus accesses and margin
    localparam int TIMEOUT_CYCLES = 24 * FRAME_CYCLES + 4080;

    logic                      sys_clk;
    logic                      rst_n;
    uart_mmio_pkg::mmio_req_t  mmio_req;
    logic                      mmio_work;
    logic                      mmio_done;
    uart_mmio_pkg::mmio_data_t mmio_read_data;
    logic                      uart_txd;
    logic                      uart_rxd;
    logic                      rxd_drv;
    logic                      loopback;
    logic                      req_outside;

    int errors    = 0;
    int checks    = 0;
    int cycle_cnt = 0;

    uart_mmio_pkg::uart_byte_t line_q[$];
    uart_mmio_pkg::uart_byte_t exp_q[$];

    mmio_uart #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_dut (
        .sys_clk        (sys_clk),
        .rst_n          (rst_n),
        .mmio_req       (mmio_req),
        .mmio_work      (mmio_work),
        .mmio_done      (mmio_done),
        .mmio_read_data (mmio_read_data),
        .uart_txd       (uart_txd),
        .uart_rxd       (uart_rxd)
    );

    // serial input comes from the driver task or straight from the transmitter
    assign uart_rxd = loopback ? uart_txd : rxd_drv;

    assign req_outside = (mmio_req.read || mmio_req.write) &&
                         ((mmio_req.addr < uart_mmio_pkg::MMIO_UART_BASE) ||
                          (mmio_req.addr > uart_mmio_pkg::MMIO_UART_BASE + 32'd31));

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    a_done_after_work: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(mmio_work) |=> mmio_done)
    else begin
        errors++;
        $display("** Error at %0t: mmio_done expected 1, got %b", $time, $sampled(mmio_done));
    end

    a_done_needs_work: assert property (@(posedge sys_clk) disable iff (!rst_n)
        mmio_done |-> ($past(mmio_work) && !$past(mmio_work, 2)))
    else begin
        errors++;
        $display("** Error at %0t: mmio_done expected 0, got %b", $time, $sampled(mmio_done));
    end

    a_done_single: assert property (@(posedge sys_clk) disable iff (!rst_n)
        mmio_done |=> !mmio_done)
    else begin
        errors++;
        $display("** Error at %0t: mmio_done expected 0, got %b", $time, $sampled(mmio_done));
    end

    a_outside_window: assert property (@(posedge sys_clk) disable iff (!rst_n)
        req_outside |-> !mmio_work)
    else begin
        errors++;
        $display("** Error at %0t: mmio_work expected 0, got %b", $time, $sampled(mmio_work));
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        end
    endtask

    function automatic uart_mmio_pkg::mmio_req_t make_req(input logic rd,
                                                          input uart_mmio_pkg::mmio_addr_t addr,
                                                          input uart_mmio_pkg::mmio_data_t wdata);
        uart_mmio_pkg::mmio_req_t r;
        r.read  = rd;
        r.write = !rd;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // hold the request until done, then drop it on the next edge
    task automatic bus_access(input logic rd, input uart_mmio_pkg::reg_offset_t off,
                              input uart_mmio_pkg::mmio_data_t wdata,
                              output uart_mmio_pkg::mmio_data_t rdata);
        int waited;
        waited = 0;
        @(posedge sys_clk);
        mmio_req <= make_req(rd, uart_mmio_pkg::MMIO_UART_BASE + 32'(off), wdata);
        do begin
            @(posedge sys_clk);
            waited++;
        end while (!mmio_done && waited < 4);
        checks++;
        assert (mmio_done) else begin
            errors++;
            $display("Bus access at offset 0x%0h never raised mmio_done", off);
        end
        rdata = mmio_read_data;
        mmio_req <= '0;
    endtask

    task automatic reg_write(input uart_mmio_pkg::reg_offset_t off,
                             input uart_mmio_pkg::mmio_data_t wdata);
        uart_mmio_pkg::mmio_data_t unused;
        bus_access(1'b0, off, wdata, unused);
    endtask

    task automatic reg_read(input uart_mmio_pkg::reg_offset_t off,
                            output uart_mmio_pkg::mmio_data_t rdata);
        bus_access(1'b1, off, '0, rdata);
    endtask

    task automatic probe_outside(input uart_mmio_pkg::mmio_addr_t addr);
        @(posedge sys_clk);
        mmio_req <= make_req(1'b1, addr, '0);
        repeat (4) begin
            @(posedge sys_clk);
            check_value("mmio_work", 32'(mmio_work), 32'd0);
            check_value("mmio_done", 32'(mmio_done), 32'd0);
        end
        mmio_req <= '0;
    endtask

    task automatic push_random_bytes(input int n);
        uart_mmio_pkg::uart_byte_t b;
        for (int i = 0; i < n; i++) begin
            b = 8'($urandom());
            exp_q.push_back(b);
            reg_write(uart_mmio_pkg::REG_TX_DATA, 32'(b));
        end
    endtask

    // start bit, lsb first data, stop bit, then one idle bit
    task automatic drive_frame(input uart_mmio_pkg::uart_byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge sys_clk);
            rxd_drv <= bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
        end
        repeat (CLKS_PER_BIT) @(posedge sys_clk);
    endtask

    task automatic drive_random_frames(input int n);
        uart_mmio_pkg::uart_byte_t b;
        for (int i = 0; i < n; i++) begin
            b = 8'($urandom());
            exp_q.push_back(b);
            drive_frame(b);
        end
    endtask

    task automatic drain_rx(input int n);
        uart_mmio_pkg::mmio_data_t rdata;
        for (int i = 0; i < n; i++) begin
            reg_read(uart_mmio_pkg::REG_RX_DATA, rdata);
            check_value("RX_DATA", rdata, 32'(exp_q.pop_front()));
        end
    endtask

    task automatic wait_frames(input int n);
        while (line_q.size() < n) begin
            @(posedge sys_clk);
        end
    endtask

    task automatic compare_line();
        check_value("frames sent", line_q.size(), exp_q.size());
        while (line_q.size() > 0 && exp_q.size() > 0) begin
            check_value("uart_txd byte", 32'(line_q.pop_front()), 32'(exp_q.pop_front()));
        end
    endtask

    task automatic close_run(input bit timed_out);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // decodes frames on uart_txd, sampling each bit in its middle
    initial begin : line_monitor
        uart_mmio_pkg::uart_byte_t b;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge sys_clk);
            if (!uart_txd) begin
                repeat (CLKS_PER_BIT / 2) @(posedge sys_clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(posedge sys_clk);
                    b[i] = uart_txd;
                end
                repeat (CLKS_PER_BIT) @(posedge sys_clk);
                check_value("uart_txd stop bit", 32'(uart_txd), 32'd1);
                line_q.push_back(b);
            end
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        close_run(1'b1);
    end

    initial begin : main
        uart_mmio_pkg::mmio_data_t rdata;
        rst_n    = 1'b0;
        mmio_req = '0;
        rxd_drv  = 1'b1;
        loopback = 1'b0;
        void'($urandom(9));
        repeat (16) @(posedge sys_clk);
        rst_n <= 1'b1;
        repeat (uart_mmio_pkg::FIFO_RST_CYCLES) @(posedge sys_clk);
        @(posedge sys_clk);
        check_value("mmio_done", 32'(mmio_done), 32'd0);
        check_value("uart_txd", 32'(uart_txd), 32'd1);

        // just below and just above the window
        probe_outside(uart_mmio_pkg::MMIO_UART_BASE - 32'd4);
        probe_outside(uart_mmio_pkg::MMIO_UART_BASE + 32'd32);
        reg_read(uart_mmio_pkg::REG_RX_VALID, rdata);
        check_value("RX_VALID", rdata, 32'd0);

        // transmit
        line_q.delete();
        exp_q.delete();
        push_random_bytes(4);
        reg_write(uart_mmio_pkg::REG_TX_CTRL, 32'd1);
        wait_frames(4);
        compare_line();
        reg_read(uart_mmio_pkg::REG_TX_CTRL, rdata);
        check_value("TX_CTRL", rdata, 32'd0);

        // receive
        exp_q.delete();
        drive_random_frames(3);
        reg_read(uart_mmio_pkg::REG_RX_VALID, rdata);
        check_value("RX_VALID", rdata, 32'd1);
        drain_rx(3);
        reg_read(uart_mmio_pkg::REG_RX_VALID, rdata);
        check_value("RX_VALID", rdata, 32'd0);

        // rx fifo holds 4, the last two frames are dropped
        exp_q.delete();
        drive_random_frames(6);
        drain_rx(FIFO_DEPTH);
        reg_read(uart_mmio_pkg::REG_RX_VALID, rdata);
        check_value("RX_VALID", rdata, 32'd0);

        // tx fifo full after the fourth write, the fifth byte is lost
        line_q.delete();
        exp_q.delete();
        push_random_bytes(4);
        reg_read(uart_mmio_pkg::REG_TX_CTRL, rdata);
        check_value("TX_CTRL", rdata, 32'd2);
        reg_write(uart_mmio_pkg::REG_TX_DATA, 32'h5A);
        reg_write(uart_mmio_pkg::REG_TX_CTRL, 32'd1);
        wait_frames(4);
        repeat (3 * FRAME_CYCLES) @(posedge sys_clk);
        compare_line();
        reg_read(uart_mmio_pkg::REG_TX_CTRL, rdata);
        check_value("TX_CTRL", rdata, 32'd0);

        // loopback
        @(posedge sys_clk);
        loopback <= 1'b1;
        line_q.delete();
        exp_q.delete();
        push_random_bytes(4);
        reg_write(uart_mmio_pkg::REG_TX_CTRL, 32'd1);
        wait_frames(4);
        repeat (2 * CLKS_PER_BIT) @(posedge sys_clk);
        reg_read(uart_mmio_pkg::REG_RX_VALID, rdata);
        check_value("RX_VALID", rdata, 32'd1);
        drain_rx(4);
        reg_read(uart_mmio_pkg::REG_RX_VALID, rdata);
        check_value("RX_VALID", rdata, 32'd0);

        close_run(1'b0);
    end

endmodule

//--- source/mmio_uart.sv
module mmio_uart #(
    parameter int CLKS_PER_BIT = 434,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic                     sys_clk,
    input  logic                     rst_n,
    input  uart_mmio_pkg::mmio_req_t  mmio_req,
    output logic                     mmio_work,
    output logic                     mmio_done,
    output uart_mmio_pkg::mmio_data_t mmio_read_data,
    output logic                     uart_txd,
    input  logic                     uart_rxd
);

    localparam int RST_CW = $clog2(uart_mmio_pkg::FIFO_RST_CYCLES);

    uart_mmio_pkg::reg_offset_t offset;
    uart_mmio_pkg::mmio_data_t  read_mux;
    uart_mmio_pkg::uart_byte_t  tx_fifo_dout;
    uart_mmio_pkg::uart_byte_t  rx_fifo_dout;
    uart_mmio_pkg::uart_byte_t  tx_byte;
    uart_mmio_pkg::uart_byte_t  rx_byte;

    logic              access;
    logic              tx_start;
    logic              tx_fifo_wr;
    logic              tx_fifo_rd;
    logic              tx_fifo_full;
    logic              tx_fifo_empty;
    logic              rx_fifo_wr;
    logic              rx_fifo_rd;
    logic              rx_fifo_full;
    logic              rx_fifo_empty;
    logic              tx_en;
    logic              tx_busy;
    logic              rx_done;
    logic              rx_done_q;
    logic              fifo_clear;
    logic [RST_CW-1:0] rst_cnt;

    assign offset    = mmio_req.addr[4:0];
    assign mmio_work = (mmio_req.read || mmio_req.write) &&
                       (mmio_req.addr[31:5] == uart_mmio_pkg::MMIO_UART_BASE[31:5]);

    // the cycle that carries done is not a new access
    assign access = mmio_work && !mmio_done;

    assign tx_fifo_wr = access && mmio_req.write && (offset == uart_mmio_pkg::REG_TX_DATA);
    assign rx_fifo_rd = access && mmio_req.read && (offset == uart_mmio_pkg::REG_RX_DATA);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            mmio_done <= 1'b0;
            tx_start  <= 1'b0;
        end else begin
            mmio_done <= access;
            if (access && mmio_req.write && offset == uart_mmio_pkg::REG_TX_CTRL) begin
                tx_start <= mmio_req.wdata[0];
            end else if (!mmio_work && !mmio_done && tx_start && tx_fifo_empty) begin
                tx_start <= 1'b0;
            end
        end
    end

    always_comb begin
        read_mux = '0;
        if (mmio_req.read) begin
            case (offset)
                uart_mmio_pkg::REG_RX_VALID: read_mux = {31'b0, !rx_fifo_empty};
                uart_mmio_pkg::REG_RX_DATA:  read_mux = rx_fifo_empty ? 32'b0 : {24'b0, rx_fifo_dout};
                uart_mmio_pkg::REG_TX_CTRL:  read_mux = {30'b0, tx_fifo_full, tx_start};
                default:                     read_mux = '0;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (access) begin
            mmio_read_data <= read_mux;
        end
    end

    byte_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) tx_fifo (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .clear   (fifo_clear),
        .din     (mmio_req.wdata[7:0]),
        .wr_en   (tx_fifo_wr),
        .rd_en   (tx_fifo_rd),
        .dout    (tx_fifo_dout),
        .full    (tx_fifo_full),
        .empty   (tx_fifo_empty)
    );

    uart_tx_sequencer tx_seq (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .start      (tx_start),
        .fifo_empty (tx_fifo_empty),
        .fifo_data  (tx_fifo_dout),
        .fifo_rd    (tx_fifo_rd),
        .tx_busy    (tx_busy),
        .tx_en      (tx_en),
        .tx_data    (tx_byte)
    );

    uart_send #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_tx (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .tx_en   (tx_en),
        .tx_data (tx_byte),
        .busy    (tx_busy),
        .txd     (uart_txd)
    );

    uart_recv #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_rx (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .rxd     (uart_rxd),
        .done    (rx_done),
        .data    (rx_byte)
    );

    // done is a level, push once on its rising edge
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rx_done_q <= 1'b0;
        end else begin
            rx_done_q <= rx_done;
        end
    end

    assign rx_fifo_wr = rx_done && !rx_done_q && !rx_fifo_full;

    byte_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) rx_fifo (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .clear   (fifo_clear),
        .din     (rx_byte),
        .wr_en   (rx_fifo_wr),
        .rd_en   (rx_fifo_rd),
        .dout    (rx_fifo_dout),
        .full    (rx_fifo_full),
        .empty   (rx_fifo_empty)
    );

    // fifo clear stays up for the first cycles after reset releases
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            fifo_clear <= 1'b1;
            rst_cnt    <= '0;
        end else if (fifo_clear) begin
            rst_cnt <= rst_cnt + 1'b1;
            if (rst_cnt == RST_CW'(uart_mmio_pkg::FIFO_RST_CYCLES - 1)) begin
                fifo_clear <= 1'b0;
            end
        end
    end

endmodule

//--- source/uart_tx_sequencer.sv
module uart_tx_sequencer (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    fifo_empty,
    input  uart_mmio_pkg::uart_byte_t fifo_data,
    output logic                    fifo_rd,
    input  logic                    tx_busy,
    output logic                    tx_en,
    output uart_mmio_pkg::uart_byte_t tx_data
);

    uart_mmio_pkg::tx_seq_state_e state;
    uart_mmio_pkg::tx_seq_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            uart_mmio_pkg::IDLE: begin
                if (start && !fifo_empty) begin
                    state_nxt = uart_mmio_pkg::CHECK;
                end
            end
            uart_mmio_pkg::CHECK: begin
                if (fifo_empty || !start) begin
                    state_nxt = uart_mmio_pkg::IDLE;
                end else if (!tx_busy) begin
                    state_nxt = uart_mmio_pkg::POP;
                end
            end
            uart_mmio_pkg::POP:    state_nxt = uart_mmio_pkg::LAUNCH;
            uart_mmio_pkg::LAUNCH: state_nxt = uart_mmio_pkg::WAIT;
            // busy is already up in the first wait cycle
            uart_mmio_pkg::WAIT: begin
                if (!tx_busy) begin
                    state_nxt = uart_mmio_pkg::CHECK;
                end
            end
            default: state_nxt = uart_mmio_pkg::IDLE;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state <= uart_mmio_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign fifo_rd = (state == uart_mmio_pkg::POP);
    assign tx_en   = (state == uart_mmio_pkg::LAUNCH);

    // head word is valid while popping, hold it for the serializer
    always_ff @(posedge sys_clk) begin
        if (fifo_rd) begin
            tx_data <= fifo_data;
        end
    end

endmodule

//--- source/uart_recv.sv
module uart_recv #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    rxd,
    output logic                    done,
    output uart_mmio_pkg::uart_byte_t data
);

    localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e                 state;
    logic                      rxd_s1;
    logic                      rxd_s2;
    logic                      rxd_d;
    logic                      start_edge;
    logic [CW-1:0]             clk_cnt;
    logic [2:0]                bit_idx;
    logic                      bit_mid;
    uart_mmio_pkg::uart_byte_t shreg;

    // two-flop synchronizer plus one more for the edge
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
            rxd_d  <= 1'b1;
        end else begin
            rxd_s1 <= rxd;
            rxd_s2 <= rxd_s1;
            rxd_d  <= rxd_s2;
        end
    end

    assign start_edge = rxd_d && !rxd_s2;
    assign bit_mid    = (clk_cnt == CW'(CLKS_PER_BIT - 1));

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            done    <= 1'b0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                        done  <= 1'b0;
                    end
                end
                // recheck the line at half a bit, a glitch goes back to idle
                RX_START: begin
                    if (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s2 ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_mid) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_mid) begin
                        state <= RX_IDLE;
                        done  <= rxd_s2;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == RX_DATA && bit_mid) begin
            shreg <= {rxd_s2, shreg[7:1]};
        end
        if (state == RX_STOP && bit_mid && rxd_s2) begin
            data <= shreg;
        end
    end

endmodule

//--- source/uart_send.sv
module uart_send #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    tx_en,
    input  uart_mmio_pkg::uart_byte_t tx_data,
    output logic                    busy,
    output logic                    txd
);

    localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [CW-1:0] clk_cnt;
    // 0 is the start bit, 9 the stop bit
    logic [3:0]    bit_cnt;
    // remaining data bits with the stop bit on top
    logic [8:0]    shreg;
    logic          bit_end;

    assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            txd     <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            if (tx_en) begin
                busy <= 1'b1;
                txd  <= 1'b0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                txd     <= shreg[0];
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // lsb goes out first, ones shift in behind it
    always_ff @(posedge sys_clk) begin
        if (!busy && tx_en) begin
            shreg <= {1'b1, tx_data};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

//--- source/byte_fifo.sv
module byte_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  uart_mmio_pkg::uart_byte_t din,
    input  logic                    wr_en,
    input  logic                    rd_en,
    output uart_mmio_pkg::uart_byte_t dout,
    output logic                    full,
    output logic                    empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    uart_mmio_pkg::uart_byte_t mem [DEPTH];

    // extra msb tells a full buffer from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // head word is visible without a read
    assign dout = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge sys_clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= din;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- source/uart_mmio_pkg.sv
package uart_mmio_pkg;

    // one serial data byte
    typedef logic [7:0]  uart_byte_t;

    // host bus address and data word
    typedef logic [31:0] mmio_addr_t;
    typedef logic [31:0] mmio_data_t;

    // byte offset inside the 32-byte register window
    typedef logic [4:0]  reg_offset_t;

    // host request, held by the host until it sees mmio_done
    typedef struct packed {
        logic       read;
        logic       write;
        mmio_addr_t addr;
        mmio_data_t wdata;
    } mmio_req_t;

    // window covers 0xFFFF0160 to 0xFFFF017F
    localparam mmio_addr_t MMIO_UART_BASE = 32'hFFFF_0160;

    // bit 0 is rx fifo not empty, read only
    localparam reg_offset_t REG_RX_VALID = 5'h00;
    // a read pops one received byte
    localparam reg_offset_t REG_RX_DATA  = 5'h04;
    // a write pushes one byte for transmit
    localparam reg_offset_t REG_TX_DATA  = 5'h08;
    // bit 0 start, bit 1 tx fifo full (read only)
    localparam reg_offset_t REG_TX_CTRL  = 5'h0C;

    // transmit sequencer
    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        POP,
        LAUNCH,
        WAIT
    } tx_seq_state_e;

    // fifos are held in clear this long after reset releases
    localparam int FIFO_RST_CYCLES = 32;

endpackage
